//--- src/proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Datapath and address widths
`define PROC_DATA_W   32
`define PROC_ADDR_W   32

// Register file geometry
`define PROC_REG_AW   5
`define PROC_NUM_REGS 32

// Bytes per word, one lane enable each
`define PROC_BYTES    4

`endif

//--- src/proc_pkg.sv
`include "proc_settings.svh"

package proc_pkg;

   // Primary opcode, bits 31:26 of every instruction
   // Zero is NOP so an all-zero word is a bubble
   typedef enum logic [5:0] {
      OP_NOP  = 6'd0,
      OP_HALT = 6'd1,
      OP_ADD  = 6'd2,
      OP_SUB  = 6'd3,
      OP_AND  = 6'd4,
      OP_XOR  = 6'd5,
      OP_ADDI = 6'd6,
      OP_LDW  = 6'd7,
      OP_LDH  = 6'd8,
      OP_LDB  = 6'd9,
      OP_STW  = 6'd10,
      OP_STH  = 6'd11,
      OP_STB  = 6'd12
   } opcode_t;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR
   } alu_op_t;

   // Data memory access size
   typedef enum logic [1:0] {
      GRAN_WORD,
      GRAN_HALF,
      GRAN_BYTE
   } mem_gran_t;

endpackage

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module fetch_stage (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    stall_i,
   input  logic                    halt_i,
   input  logic [`PROC_ADDR_W-1:0] dec_pc_i,
   output logic [`PROC_ADDR_W-1:0] iaddr_o
);

   localparam logic [`PROC_ADDR_W-1:0] PC_STEP = `PROC_BYTES;

   logic [`PROC_ADDR_W-1:0] pc_q;

   // Load-use stall refetches the instruction held in decode
   assign iaddr_o = stall_i ? dec_pc_i : pc_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q <= '0;
      end else if (!halt_i) begin
         pc_q <= iaddr_o + PC_STEP;
      end
   end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module decode_stage (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PROC_DATA_W-1:0] inst_i,
   input  logic                    stall_i,
   input  logic                    wb_we_i,
   input  logic [`PROC_REG_AW-1:0] wb_dest_i,
   input  logic [`PROC_DATA_W-1:0] wb_data_i,
   output logic [`PROC_ADDR_W-1:0] dec_pc_o,
   output logic                    halt_seen_o,
   output logic [`PROC_REG_AW-1:0] dec_rs_o,
   output logic [`PROC_REG_AW-1:0] dec_rt_o,
   output proc_pkg::opcode_t       ex_op_o,
   output proc_pkg::alu_op_t       ex_alu_op_o,
   output proc_pkg::mem_gran_t     ex_gran_o,
   output logic [`PROC_REG_AW-1:0] ex_rs_o,
   output logic [`PROC_REG_AW-1:0] ex_rt_o,
   output logic [`PROC_REG_AW-1:0] ex_dest_o,
   output logic                    ex_we_o,
   output logic                    ex_rd_mem_o,
   output logic                    ex_wr_mem_o,
   output logic [`PROC_DATA_W-1:0] ex_a_o,
   output logic [`PROC_DATA_W-1:0] ex_b_o,
   output logic [`PROC_DATA_W-1:0] ex_imm_o,
   output logic                    ex_illegal_o
);

   localparam logic [`PROC_ADDR_W-1:0] PC_STEP = `PROC_BYTES;

   logic [`PROC_DATA_W-1:0] regs [`PROC_NUM_REGS];
   logic [`PROC_DATA_W-1:0] rs_val;
   logic [`PROC_DATA_W-1:0] rt_val;
   logic [`PROC_REG_AW-1:0] dest;
   proc_pkg::opcode_t       op;
   proc_pkg::alu_op_t       alu_op;
   proc_pkg::mem_gran_t     gran;
   logic                    valid_q;
   logic                    halt_q;
   logic                    bubble;
   logic                    reg_we;
   logic                    mem_rd;
   logic                    mem_wr;
   logic                    illegal;

   assign op       = proc_pkg::opcode_t'(inst_i[31:26]);
   assign dec_rs_o = inst_i[25:21];
   assign dec_rt_o = inst_i[20:16];

   // Word seen in the first cycle after reset was fetched during reset
   assign bubble      = stall_i | ~valid_q | halt_q;
   assign halt_seen_o = halt_q | (valid_q & (op == proc_pkg::OP_HALT));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q  <= 1'b0;
         halt_q   <= 1'b0;
         dec_pc_o <= '0;
      end else begin
         valid_q <= 1'b1;
         if (!bubble) begin
            dec_pc_o <= dec_pc_o + PC_STEP;
            halt_q   <= (op == proc_pkg::OP_HALT);
         end
      end
   end

   ////////////////////
   // Register file
   ////////////////////

   // Write-first, the retiring value is visible to decode at once
   assign rs_val = (wb_we_i && wb_dest_i == dec_rs_o) ? wb_data_i : regs[dec_rs_o];
   assign rt_val = (wb_we_i && wb_dest_i == dec_rt_o) ? wb_data_i : regs[dec_rt_o];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_we_i) begin
         regs[wb_dest_i] <= wb_data_i;
      end
   end

   ////////////////////
   // Control decode
   ////////////////////

   always_comb begin
      reg_we  = 1'b0;
      mem_rd  = 1'b0;
      mem_wr  = 1'b0;
      illegal = 1'b0;
      alu_op  = proc_pkg::ALU_ADD;
      gran    = proc_pkg::GRAN_WORD;
      dest    = inst_i[15:11];
      case (op)
         proc_pkg::OP_NOP, proc_pkg::OP_HALT: begin
         end
         proc_pkg::OP_ADD: reg_we = 1'b1;
         proc_pkg::OP_SUB: begin
            reg_we = 1'b1;
            alu_op = proc_pkg::ALU_SUB;
         end
         proc_pkg::OP_AND: begin
            reg_we = 1'b1;
            alu_op = proc_pkg::ALU_AND;
         end
         proc_pkg::OP_XOR: begin
            reg_we = 1'b1;
            alu_op = proc_pkg::ALU_XOR;
         end
         proc_pkg::OP_ADDI: begin
            reg_we = 1'b1;
            dest   = inst_i[20:16];
         end
         proc_pkg::OP_LDW, proc_pkg::OP_LDH, proc_pkg::OP_LDB: begin
            reg_we = 1'b1;
            mem_rd = 1'b1;
            dest   = inst_i[20:16];
         end
         proc_pkg::OP_STW, proc_pkg::OP_STH, proc_pkg::OP_STB: mem_wr = 1'b1;
         default: illegal = 1'b1;
      endcase
      if (op == proc_pkg::OP_LDH || op == proc_pkg::OP_STH) begin
         gran = proc_pkg::GRAN_HALF;
      end else if (op == proc_pkg::OP_LDB || op == proc_pkg::OP_STB) begin
         gran = proc_pkg::GRAN_BYTE;
      end
   end

   // ID/EX, controls squashed on a bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_op_o      <= proc_pkg::OP_NOP;
         ex_we_o      <= 1'b0;
         ex_rd_mem_o  <= 1'b0;
         ex_wr_mem_o  <= 1'b0;
         ex_illegal_o <= 1'b0;
      end else begin
         ex_op_o      <= (bubble || illegal) ? proc_pkg::OP_NOP : op;
         ex_we_o      <= reg_we & ~bubble;
         ex_rd_mem_o  <= mem_rd & ~bubble;
         ex_wr_mem_o  <= mem_wr & ~bubble;
         ex_illegal_o <= illegal & ~bubble;
      end
   end

   always_ff @(posedge clk) begin
      ex_alu_op_o <= alu_op;
      ex_gran_o   <= gran;
      ex_rs_o     <= dec_rs_o;
      ex_rt_o     <= dec_rt_o;
      ex_dest_o   <= dest;
      ex_a_o      <= rs_val;
      ex_b_o      <= rt_val;
      ex_imm_o    <= {{(`PROC_DATA_W-16){inst_i[15]}}, inst_i[15:0]};
   end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module execute_stage (
   input  logic                    clk,
   input  logic                    rst_n,
   input  proc_pkg::opcode_t       ex_op_i,
   input  proc_pkg::alu_op_t       ex_alu_op_i,
   input  proc_pkg::mem_gran_t     ex_gran_i,
   input  logic [`PROC_REG_AW-1:0] ex_dest_i,
   input  logic                    ex_we_i,
   input  logic                    ex_rd_mem_i,
   input  logic                    ex_wr_mem_i,
   input  logic [`PROC_DATA_W-1:0] ex_a_i,
   input  logic [`PROC_DATA_W-1:0] ex_b_i,
   input  logic [`PROC_DATA_W-1:0] ex_imm_i,
   input  logic                    ex_illegal_i,
   input  logic [1:0]              fwd_a_i,
   input  logic [1:0]              fwd_b_i,
   input  logic [`PROC_DATA_W-1:0] wb_data_i,
   output logic [`PROC_DATA_W-1:0] mem_alu_o,
   output logic [`PROC_DATA_W-1:0] mem_store_o,
   output logic [`PROC_REG_AW-1:0] mem_dest_o,
   output logic                    mem_we_o,
   output logic                    mem_rd_o,
   output logic                    mem_wr_o,
   output proc_pkg::mem_gran_t     mem_gran_o,
   output logic                    mem_halt_o,
   output logic                    mem_illegal_o
);

   logic [`PROC_DATA_W-1:0] opnd_a;
   logic [`PROC_DATA_W-1:0] opnd_b;
   logic [`PROC_DATA_W-1:0] alu_b;
   logic [`PROC_DATA_W-1:0] alu_res;

   // Bit 0 selects the memory stage, bit 1 writeback
   assign opnd_a = fwd_a_i[0] ? mem_alu_o : (fwd_a_i[1] ? wb_data_i : ex_a_i);
   assign opnd_b = fwd_b_i[0] ? mem_alu_o : (fwd_b_i[1] ? wb_data_i : ex_b_i);

   // R-format takes rt, the rest add the immediate
   always_comb begin
      case (ex_op_i)
         proc_pkg::OP_ADD, proc_pkg::OP_SUB,
         proc_pkg::OP_AND, proc_pkg::OP_XOR: alu_b = opnd_b;
         default:                            alu_b = ex_imm_i;
      endcase
   end

   always_comb begin
      case (ex_alu_op_i)
         proc_pkg::ALU_SUB: alu_res = opnd_a - alu_b;
         proc_pkg::ALU_AND: alu_res = opnd_a & alu_b;
         proc_pkg::ALU_XOR: alu_res = opnd_a ^ alu_b;
         default:           alu_res = opnd_a + alu_b;
      endcase
   end

   // EX/MEM
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_we_o      <= 1'b0;
         mem_rd_o      <= 1'b0;
         mem_wr_o      <= 1'b0;
         mem_halt_o    <= 1'b0;
         mem_illegal_o <= 1'b0;
      end else begin
         mem_we_o      <= ex_we_i;
         mem_rd_o      <= ex_rd_mem_i;
         mem_wr_o      <= ex_wr_mem_i;
         mem_halt_o    <= (ex_op_i == proc_pkg::OP_HALT);
         mem_illegal_o <= ex_illegal_i;
      end
   end

   always_ff @(posedge clk) begin
      mem_alu_o   <= alu_res;
      mem_store_o <= opnd_b;
      mem_dest_o  <= ex_dest_i;
      mem_gran_o  <= ex_gran_i;
   end

endmodule

//--- src/mem_access.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module mem_access (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PROC_DATA_W-1:0] mem_alu_i,
   input  logic [`PROC_DATA_W-1:0] mem_store_i,
   input  logic [`PROC_REG_AW-1:0] mem_dest_i,
   input  logic                    mem_we_i,
   input  logic                    mem_rd_i,
   input  logic                    mem_wr_i,
   input  proc_pkg::mem_gran_t     mem_gran_i,
   input  logic                    mem_halt_i,
   input  logic                    mem_illegal_i,
   input  logic [`PROC_DATA_W-1:0] data_mem_to_proc_i,
   output logic [`PROC_ADDR_W-1:0] daddr_o,
   output logic [`PROC_BYTES-1:0]  we_o,
   output logic [`PROC_BYTES-1:0]  re_o,
   output logic [`PROC_DATA_W-1:0] data_proc_to_mem_o,
   output logic                    wb_we_o,
   output logic [`PROC_REG_AW-1:0] wb_dest_o,
   output logic [`PROC_DATA_W-1:0] wb_data_o,
   output logic                    halt_o,
   output logic                    err_o
);

   logic [1:0]              offset;
   logic [`PROC_BYTES-1:0]  lanes;
   logic                    misaligned;
   logic                    load_q;
   logic [1:0]              offset_q;
   proc_pkg::mem_gran_t     gran_q;
   logic [`PROC_DATA_W-1:0] alu_q;
   logic [`PROC_DATA_W-1:0] half_sh;
   logic [`PROC_DATA_W-1:0] byte_sh;
   logic [`PROC_DATA_W-1:0] load_data;

   ////////////////////
   // Memory stage
   ////////////////////

   assign daddr_o = mem_alu_i[`PROC_ADDR_W-1:0];
   assign offset  = mem_alu_i[1:0];

   // Big-endian lanes, offset 0 is lane 3
   always_comb begin
      case (mem_gran_i)
         proc_pkg::GRAN_HALF: lanes = 4'b1100 >> offset;
         proc_pkg::GRAN_BYTE: lanes = 4'b1000 >> offset;
         default:             lanes = 4'b1111;
      endcase
   end

   // Odd half-word offsets drop the access entirely
   assign misaligned = (mem_rd_i | mem_wr_i) & (mem_gran_i == proc_pkg::GRAN_HALF) & offset[0];

   assign we_o = (mem_wr_i && !misaligned) ? lanes : '0;
   assign re_o = (mem_rd_i && !misaligned) ? lanes : '0;

   // Replicate the field so every enabled lane carries it
   always_comb begin
      case (mem_gran_i)
         proc_pkg::GRAN_HALF: data_proc_to_mem_o = {2{mem_store_i[15:0]}};
         proc_pkg::GRAN_BYTE: data_proc_to_mem_o = {4{mem_store_i[7:0]}};
         default:             data_proc_to_mem_o = mem_store_i;
      endcase
   end

   ////////////////////
   // Writeback
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_we_o <= 1'b0;
         load_q  <= 1'b0;
         halt_o  <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         wb_we_o <= mem_we_i & ~misaligned;
         load_q  <= mem_rd_i;
         halt_o  <= halt_o | mem_halt_i;
         err_o   <= err_o | mem_illegal_i | misaligned;
      end
   end

   always_ff @(posedge clk) begin
      wb_dest_o <= mem_dest_i;
      alu_q     <= mem_alu_i;
      gran_q    <= mem_gran_i;
      offset_q  <= offset;
   end

   // Load word arrives now, move the addressed field down
   assign half_sh = data_mem_to_proc_i >> {~offset_q[1], 4'b0000};
   assign byte_sh = data_mem_to_proc_i >> {~offset_q, 3'b000};

   always_comb begin
      case (gran_q)
         proc_pkg::GRAN_HALF: load_data = {{(`PROC_DATA_W-16){1'b0}}, half_sh[15:0]};
         proc_pkg::GRAN_BYTE: load_data = {{(`PROC_DATA_W-8){1'b0}}, byte_sh[7:0]};
         default:             load_data = data_mem_to_proc_i;
      endcase
   end

   assign wb_data_o = load_q ? load_data : alu_q;

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module hazard_unit (
   input  logic [`PROC_REG_AW-1:0] dec_rs_i,
   input  logic [`PROC_REG_AW-1:0] dec_rt_i,
   input  logic                    ex_rd_mem_i,
   input  logic [`PROC_REG_AW-1:0] ex_dest_i,
   input  logic [`PROC_REG_AW-1:0] ex_rs_i,
   input  logic [`PROC_REG_AW-1:0] ex_rt_i,
   input  logic                    mem_we_i,
   input  logic [`PROC_REG_AW-1:0] mem_dest_i,
   input  logic                    wb_we_i,
   input  logic [`PROC_REG_AW-1:0] wb_dest_i,
   output logic                    stall_o,
   output logic [1:0]              fwd_a_o,
   output logic [1:0]              fwd_b_o
);

   // One-hot select, the memory stage wins as the younger writer
   function automatic logic [1:0] fwd_sel(input logic [`PROC_REG_AW-1:0] src);
      logic mem_hit;
      logic wb_hit;
      mem_hit = mem_we_i && (mem_dest_i == src);
      wb_hit  = wb_we_i && (wb_dest_i == src);
      return {wb_hit & ~mem_hit, mem_hit};
   endfunction

   // Load data is not ready until writeback, so hold decode one cycle
   assign stall_o = ex_rd_mem_i && (ex_dest_i == dec_rs_i || ex_dest_i == dec_rt_i);

   always_comb begin
      fwd_a_o = fwd_sel(ex_rs_i);
      fwd_b_o = fwd_sel(ex_rt_i);
   end

endmodule

//--- src/proc_top.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PROC_DATA_W-1:0] inst_i,
   input  logic [`PROC_DATA_W-1:0] data_mem_to_proc_i,
   output logic [`PROC_ADDR_W-1:0] iaddr_o,
   output logic [`PROC_ADDR_W-1:0] daddr_o,
   output logic [`PROC_BYTES-1:0]  we_o,
   output logic [`PROC_BYTES-1:0]  re_o,
   output logic [`PROC_DATA_W-1:0] data_proc_to_mem_o,
   output logic                    err_o,
   output logic                    halt_o
);

   // Fetch and decode
   logic                    stall;
   logic                    halt_seen;
   logic [`PROC_ADDR_W-1:0] dec_pc;
   logic [`PROC_REG_AW-1:0] dec_rs;
   logic [`PROC_REG_AW-1:0] dec_rt;

   // ID/EX
   proc_pkg::opcode_t       ex_op;
   proc_pkg::alu_op_t       ex_alu_op;
   proc_pkg::mem_gran_t     ex_gran;
   logic [`PROC_REG_AW-1:0] ex_rs;
   logic [`PROC_REG_AW-1:0] ex_rt;
   logic [`PROC_REG_AW-1:0] ex_dest;
   logic                    ex_we;
   logic                    ex_rd_mem;
   logic                    ex_wr_mem;
   logic [`PROC_DATA_W-1:0] ex_a;
   logic [`PROC_DATA_W-1:0] ex_b;
   logic [`PROC_DATA_W-1:0] ex_imm;
   logic                    ex_illegal;
   logic [1:0]              fwd_a;
   logic [1:0]              fwd_b;

   // EX/MEM
   logic [`PROC_DATA_W-1:0] mem_alu;
   logic [`PROC_DATA_W-1:0] mem_store;
   logic [`PROC_REG_AW-1:0] mem_dest;
   logic                    mem_we;
   logic                    mem_rd;
   logic                    mem_wr;
   proc_pkg::mem_gran_t     mem_gran;
   logic                    mem_halt;
   logic                    mem_illegal;

   // Writeback
   logic                    wb_we;
   logic [`PROC_REG_AW-1:0] wb_dest;
   logic [`PROC_DATA_W-1:0] wb_data;

   fetch_stage u_fetch (
      .clk(clk), .rst_n(rst_n), .stall_i(stall), .halt_i(halt_seen),
      .dec_pc_i(dec_pc), .iaddr_o(iaddr_o)
   );

   decode_stage u_decode (
      .clk(clk), .rst_n(rst_n), .inst_i(inst_i), .stall_i(stall),
      .wb_we_i(wb_we), .wb_dest_i(wb_dest), .wb_data_i(wb_data),
      .dec_pc_o(dec_pc), .halt_seen_o(halt_seen), .dec_rs_o(dec_rs), .dec_rt_o(dec_rt),
      .ex_op_o(ex_op), .ex_alu_op_o(ex_alu_op), .ex_gran_o(ex_gran),
      .ex_rs_o(ex_rs), .ex_rt_o(ex_rt), .ex_dest_o(ex_dest), .ex_we_o(ex_we),
      .ex_rd_mem_o(ex_rd_mem), .ex_wr_mem_o(ex_wr_mem),
      .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_imm_o(ex_imm), .ex_illegal_o(ex_illegal)
   );

   hazard_unit u_hazard (
      .dec_rs_i(dec_rs), .dec_rt_i(dec_rt), .ex_rd_mem_i(ex_rd_mem), .ex_dest_i(ex_dest),
      .ex_rs_i(ex_rs), .ex_rt_i(ex_rt), .mem_we_i(mem_we), .mem_dest_i(mem_dest),
      .wb_we_i(wb_we), .wb_dest_i(wb_dest),
      .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
   );

   execute_stage u_execute (
      .clk(clk), .rst_n(rst_n), .ex_op_i(ex_op), .ex_alu_op_i(ex_alu_op),
      .ex_gran_i(ex_gran), .ex_dest_i(ex_dest), .ex_we_i(ex_we),
      .ex_rd_mem_i(ex_rd_mem), .ex_wr_mem_i(ex_wr_mem),
      .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_imm_i(ex_imm), .ex_illegal_i(ex_illegal),
      .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .wb_data_i(wb_data),
      .mem_alu_o(mem_alu), .mem_store_o(mem_store), .mem_dest_o(mem_dest),
      .mem_we_o(mem_we), .mem_rd_o(mem_rd), .mem_wr_o(mem_wr), .mem_gran_o(mem_gran),
      .mem_halt_o(mem_halt), .mem_illegal_o(mem_illegal)
   );

   mem_access u_mem (
      .clk(clk), .rst_n(rst_n), .mem_alu_i(mem_alu), .mem_store_i(mem_store),
      .mem_dest_i(mem_dest), .mem_we_i(mem_we), .mem_rd_i(mem_rd), .mem_wr_i(mem_wr),
      .mem_gran_i(mem_gran), .mem_halt_i(mem_halt), .mem_illegal_i(mem_illegal),
      .data_mem_to_proc_i(data_mem_to_proc_i),
      .daddr_o(daddr_o), .we_o(we_o), .re_o(re_o), .data_proc_to_mem_o(data_proc_to_mem_o),
      .wb_we_o(wb_we), .wb_dest_o(wb_dest), .wb_data_o(wb_data),
      .halt_o(halt_o), .err_o(err_o)
   );

endmodule

//--- verification/proc_asserts.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_asserts (
   input logic                   clk,
   input logic                   rst_n,
   input logic [`PROC_BYTES-1:0] we_o,
   input logic [`PROC_BYTES-1:0] re_o,
   input logic                   halt_o,
   input logic                   err_o
);

   // A single access is either a read or a write
   a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !((|we_o) && (|re_o)))
      else $error("we_o and re_o active together");

   // Word, aligned half-words and single bytes only
   a_we_legal: assert property (@(posedge clk) disable iff (!rst_n)
      we_o inside {4'b0000, 4'b1111, 4'b1100, 4'b0011,
                   4'b1000, 4'b0100, 4'b0010, 4'b0001})
      else $error("illegal we_o pattern %b", we_o);

   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      halt_o |=> halt_o)
      else $error("halt_o fell out of reset");

   a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      err_o |=> err_o)
      else $error("err_o fell out of reset");

endmodule

//--- verification/proc_monitor.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_monitor (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PROC_ADDR_W-1:0] iaddr_i,
   input  logic [`PROC_ADDR_W-1:0] daddr_i,
   input  logic [`PROC_BYTES-1:0]  we_i,
   input  logic [`PROC_BYTES-1:0]  re_i,
   input  logic [`PROC_DATA_W-1:0] data_i,
   input  logic                    halt_i,
   input  logic                    err_i,
   input  logic                    end_chk_i,
   output int                      checks_o,
   output int                      errors_o
);

   logic [31:0] exp_addr [$];
   logic [3:0]  exp_mask [$];
   logic [31:0] exp_data [$];
   logic        exp_err;
   logic [31:0] exp_iaddr;
   int          exp_reads;
   int          wr_idx;
   int          reads_seen;
   logic        built;

   function automatic logic [31:0] lane_bits(input logic [3:0] m);
      logic [31:0] b;
      for (int k = 0; k < 4; k++) begin
         b[k*8 +: 8] = {8{m[k]}};
      end
      return b;
   endfunction

   // Sequential ISA model of the program in the testbench memories
   function automatic void run_reference();
      logic [31:0] r [32];
      logic [31:0] m [256];
      logic [31:0] inst, imm, ea, w, val, sd;
      logic [3:0]  mask;
      logic [4:0]  rs, rt, rd;
      logic [31:0] pc;
      proc_pkg::opcode_t op;
      exp_addr.delete();
      exp_mask.delete();
      exp_data.delete();
      exp_err   = 1'b0;
      exp_reads = 0;
      pc        = 0;
      for (int i = 0; i < 32; i++) r[i] = '0;
      for (int i = 0; i < 256; i++) m[i] = proc_tb.dmem[i];
      for (int n = 0; n < 4096; n++) begin
         inst = proc_tb.imem[pc[11:2]];
         op   = proc_pkg::opcode_t'(inst[31:26]);
         rs   = inst[25:21];
         rt   = inst[20:16];
         rd   = inst[15:11];
         imm  = {{16{inst[15]}}, inst[15:0]};
         ea   = r[rs] + imm;
         pc   = pc + 4;
         case (op)
            proc_pkg::OP_NOP: ;
            proc_pkg::OP_HALT: break;
            proc_pkg::OP_ADD:  r[rd] = r[rs] + r[rt];
            proc_pkg::OP_SUB:  r[rd] = r[rs] - r[rt];
            proc_pkg::OP_AND:  r[rd] = r[rs] & r[rt];
            proc_pkg::OP_XOR:  r[rd] = r[rs] ^ r[rt];
            proc_pkg::OP_ADDI: r[rt] = r[rs] + imm;
            proc_pkg::OP_LDW, proc_pkg::OP_LDH, proc_pkg::OP_LDB: begin
               if (op == proc_pkg::OP_LDH && ea[0]) begin
                  exp_err = 1'b1;
               end else begin
                  w = m[ea[9:2]];
                  if (op == proc_pkg::OP_LDW) val = w;
                  else if (op == proc_pkg::OP_LDH) val = ea[1] ? w[15:0] : w[31:16];
                  else val = (w >> ((3 - ea[1:0]) * 8)) & 32'hFF;
                  r[rt] = val;
                  exp_reads++;
               end
            end
            proc_pkg::OP_STW, proc_pkg::OP_STH, proc_pkg::OP_STB: begin
               if (op == proc_pkg::OP_STH && ea[0]) begin
                  exp_err = 1'b1;
               end else begin
                  if (op == proc_pkg::OP_STW) begin
                     mask = 4'b1111;
                     sd   = r[rt];
                  end else if (op == proc_pkg::OP_STH) begin
                     mask = 4'b1100 >> ea[1:0];
                     sd   = {2{r[rt][15:0]}};
                  end else begin
                     mask = 4'b1000 >> ea[1:0];
                     sd   = {4{r[rt][7:0]}};
                  end
                  sd = sd & lane_bits(mask);
                  m[ea[9:2]] = (m[ea[9:2]] & ~lane_bits(mask)) | sd;
                  exp_addr.push_back({ea[31:2], 2'b00});
                  exp_mask.push_back(mask);
                  exp_data.push_back(sd);
               end
            end
            default: exp_err = 1'b1;
         endcase
      end
      // Fetch stays frozen one word past HALT
      exp_iaddr = pc;
   endfunction

   function automatic void report_value(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
         errors_o++;
      end
   endfunction

   initial begin
      checks_o = 0;
      errors_o = 0;
      built    = 1'b0;
   end

   // Compare process, samples values settled in the cycle just ended
   always @(posedge clk) begin
      if (!rst_n) begin
         built <= 1'b0;
      end else begin
         if (!built) begin
            run_reference();
            wr_idx     = 0;
            reads_seen = 0;
            built     <= 1'b1;
         end
         if (|re_i) reads_seen++;
         if (|we_i) begin
            checks_o++;
            if (halt_i) begin
               $display("Store activity after halt_o at %0t ns", $time);
               errors_o++;
            end else if (wr_idx >= exp_addr.size()) begin
               $display("Unexpected extra store at %0t ns to %h", $time, daddr_i);
               errors_o++;
            end else begin
               report_value("daddr_o", {daddr_i[31:2], 2'b00}, exp_addr[wr_idx]);
               report_value("we_o", we_i, exp_mask[wr_idx]);
               report_value("data_proc_to_mem_o", data_i & lane_bits(we_i),
                            exp_data[wr_idx]);
               wr_idx++;
            end
         end
         if (end_chk_i) begin
            checks_o++;
            if (wr_idx != exp_addr.size()) begin
               $display("Only %0d of %0d stores seen", wr_idx, exp_addr.size());
               errors_o++;
            end
            report_value("err_o", err_i, exp_err);
            report_value("halt_o", halt_i, 1'b1);
            report_value("iaddr_o", iaddr_i, exp_iaddr);
            report_value("read count", reads_seen, exp_reads);
         end
      end
   end

endmodule

//--- verification/proc_tb.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_tb;

   logic        clk;
   logic        rst_n;
   logic [31:0] inst_i;
   logic [31:0] data_mem_to_proc_i;
   logic [31:0] iaddr_o;
   logic [31:0] daddr_o;
   logic [3:0]  we_o;
   logic [3:0]  re_o;
   logic [31:0] data_proc_to_mem_o;
   logic        err_o;
   logic        halt_o;
   logic        end_chk;
   int          checks;
   int          errors;

   logic [31:0] imem [1024];
   logic [31:0] dmem [256];
   logic [31:0] lfsr_state;
   int          pc_words;
   logic        timed_out;

   proc_top u_dut (
      .clk(clk), .rst_n(rst_n), .inst_i(inst_i), .data_mem_to_proc_i(data_mem_to_proc_i),
      .iaddr_o(iaddr_o), .daddr_o(daddr_o), .we_o(we_o), .re_o(re_o),
      .data_proc_to_mem_o(data_proc_to_mem_o), .err_o(err_o), .halt_o(halt_o)
   );

   proc_monitor u_mon (
      .clk(clk), .rst_n(rst_n), .iaddr_i(iaddr_o), .daddr_i(daddr_o), .we_i(we_o),
      .re_i(re_o), .data_i(data_proc_to_mem_o), .halt_i(halt_o), .err_i(err_o),
      .end_chk_i(end_chk), .checks_o(checks), .errors_o(errors)
   );

   bind proc_top proc_asserts u_asserts (
      .clk(clk), .rst_n(rst_n), .we_o(we_o), .re_o(re_o), .halt_o(halt_o), .err_o(err_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Memories answer one cycle after the address
   always @(posedge clk) begin
      inst_i             <= imem[iaddr_o[11:2]];
      data_mem_to_proc_i <= dmem[daddr_o[9:2]];
      for (int k = 0; k < 4; k++) begin
         if (we_o[k]) dmem[daddr_o[9:2]][k*8 +: 8] <= data_proc_to_mem_o[k*8 +: 8];
      end
   end

   ////////////////////
   // Program generation
   ////////////////////

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
      end
      return v;
   endfunction

   function automatic logic [4:0] pick_reg();
      return 5'(take_bits(3) % 7 + 1);
   endfunction

   function automatic logic [31:0] encode_r(input proc_pkg::opcode_t op,
                                            input logic [4:0] rd, rs, rt);
      return {op, rs, rt, rd, 11'd0};
   endfunction

   function automatic logic [31:0] encode_i(input proc_pkg::opcode_t op,
                                            input logic [4:0] rt, rs,
                                            input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic emit(input logic [31:0] w);
      imem[pc_words] = w;
      pc_words++;
   endtask

   // Base register set up by ADDI, then the access itself
   task automatic emit_access(input logic is_store, input logic [4:0] data_reg,
                              input logic [1:0] kind);
      logic [4:0]  base;
      logic [15:0] off;
      base = pick_reg();
      emit(encode_i(proc_pkg::OP_ADDI, base, 5'd0, 16'h100 + 16'(take_bits(4) << 2)));
      if (kind == 2'd0) begin
         off = 16'd0;
         emit(encode_i(is_store ? proc_pkg::OP_STW : proc_pkg::OP_LDW, data_reg, base, off));
      end else if (kind == 2'd1) begin
         off = 16'(take_bits(1) << 1);
         emit(encode_i(is_store ? proc_pkg::OP_STH : proc_pkg::OP_LDH, data_reg, base, off));
      end else begin
         off = 16'(take_bits(2));
         emit(encode_i(is_store ? proc_pkg::OP_STB : proc_pkg::OP_LDB, data_reg, base, off));
      end
   endtask

   task automatic emit_epilogue();
      for (int i = 1; i < 8; i++) begin
         emit(encode_i(proc_pkg::OP_STW, 5'(i), 5'd0, 16'h200 + 16'(i * 4)));
      end
      emit(encode_i(proc_pkg::OP_HALT, 5'd0, 5'd0, 16'd0));
      // Stores past HALT must never issue
      for (int i = 1; i < 4; i++) begin
         emit(encode_i(proc_pkg::OP_STW, 5'(i), 5'd0, 16'h240 + 16'(i * 4)));
      end
   endtask

   task automatic build_program(input int run);
      logic [4:0]        a;
      logic [4:0]        b;
      proc_pkg::opcode_t ops [4];
      ops = '{proc_pkg::OP_ADD, proc_pkg::OP_SUB, proc_pkg::OP_AND, proc_pkg::OP_XOR};
      pc_words = 0;
      for (int i = 0; i < 1024; i++) imem[i] = '0;
      for (int i = 0; i < 256; i++) begin
         dmem[i] = (i * 32'h9E3779B1) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5A};
      end
      if (run == 0) begin
         for (int i = 1; i < 8; i++) begin
            emit(encode_i(proc_pkg::OP_ADDI, 5'(i), 5'd0, 16'(take_bits(16))));
         end
         // Load then immediate use, then a dependent ALU chain
         emit_access(1'b0, 5'd5, 2'd0);
         emit(encode_r(proc_pkg::OP_ADD, 5'd4, 5'd5, 5'd5));
         emit(encode_r(proc_pkg::OP_ADD, 5'd1, 5'd2, 5'd3));
         emit(encode_r(proc_pkg::OP_SUB, 5'd2, 5'd1, 5'd1));
         emit(encode_r(proc_pkg::OP_XOR, 5'd3, 5'd2, 5'd1));
         while (pc_words < 190) begin
            case (take_bits(3))
               5: emit_access(1'b0, pick_reg(), 2'(take_bits(2)));
               6: emit_access(1'b1, pick_reg(), 2'(take_bits(2)));
               4: emit(encode_i(proc_pkg::OP_ADDI, pick_reg(), pick_reg(),
                                16'(take_bits(16))));
               7: begin
                  a = pick_reg();
                  b = pick_reg();
                  emit_access(1'b0, a, 2'(take_bits(2)));
                  emit(encode_r(proc_pkg::OP_XOR, b, pick_reg(), a));
               end
               default: emit(encode_r(ops[2'(take_bits(2))],
                                      pick_reg(), pick_reg(), pick_reg()));
            endcase
         end
      end else begin
         emit(encode_i(proc_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
         emit(32'hFC000000);
         emit(encode_i(proc_pkg::OP_ADDI, 5'd2, 5'd0, 16'h103));
         emit(encode_i(proc_pkg::OP_LDH, 5'd3, 5'd2, 16'd0));
         emit(encode_r(proc_pkg::OP_ADD, 5'd4, 5'd1, 5'd3));
      end
      emit_epilogue();
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      int cyc;
      rst_n              = 1'b0;
      inst_i             = '0;
      data_mem_to_proc_i = '0;
      end_chk            = 1'b0;
      timed_out          = 1'b0;
      lfsr_state         = 32'he9680198;
      for (int run = 0; run < 2 && !timed_out; run++) begin
         @(posedge clk);
         rst_n <= 1'b0;
         build_program(run);
         repeat (16) @(posedge clk);
         rst_n <= 1'b1;
         cyc = 0;
         while (!halt_o && cyc < 5000) begin
            @(posedge clk);
            cyc++;
         end
         if (!halt_o) begin
            $display("Timeout, halt_o never rose in run %0d", run);
            timed_out = 1'b1;
         end else begin
            // Quiet window after halt, watched by the monitor
            repeat (20) @(posedge clk);
            end_chk <= 1'b1;
            @(posedge clk);
            end_chk <= 1'b0;
            @(posedge clk);
         end
      end
      $display("Checks %0d, errors %0d", checks, errors);
      if (!timed_out && errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- sim.f
+incdir+src
src/proc_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_access.sv
src/hazard_unit.sv
src/proc_top.sv
verification/proc_asserts.sv
verification/proc_monitor.sv
verification/proc_tb.sv

//--- Bender.yml
package:
  name: proc_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/proc_pkg.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/mem_access.sv
      - src/hazard_unit.sv
      - src/proc_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/proc_asserts.sv
      - verification/proc_monitor.sv
      - verification/proc_tb.sv
